// ==== rtl/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // architectural register file
    localparam int AREG_NUM = 32;
    localparam int AREG_W   = 5;

    // reorder buffer
    localparam int ROB_DEPTH    = 64;
    localparam int ROB_W        = 6;
    localparam int ROB_HEADROOM = ROB_DEPTH - 4; // worst case two bundles in flight

    localparam int XLEN = 32;

    // one mapping in either alias table
    // check flips each time an id is handed out again after wrap
    typedef struct packed {
        logic             check;
        logic [ROB_W-1:0] robid;
    } rat_entry_t;

endpackage

`default_nettype wire

// ==== rtl/rename_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_ctrl import rename_pkg::*; (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    flush_i,
    input  wire                    in_valid_i,
    input  wire  [1:0]             lane_valid_i,
    input  wire  [1:0][AREG_W-1:0] dst_areg_i,
    input  wire  [1:0]             dst_we_i,
    input  wire                    out_ready_i,
    input  wire  [1:0]             retire_i,
    input  wire  [1:0]             ret_we_i,
    input  wire  [1:0][AREG_W-1:0] ret_areg_i,
    output logic                   in_ready_o,
    output logic [1:0]             issue_o,
    output logic [1:0]             spec_we_o,
    output logic [1:0]             commit_we_o,
    output logic [1:0][ROB_W-1:0]  dst_robid_o
);

    logic [ROB_W:0]   rob_cnt_q, rob_cnt_d;   // one extra bit, count reaches 64
    logic [ROB_W-1:0] head_q, head_d;
    logic             rob_avail_q;
    logic [ROB_W:0]   n_issue, n_retire;

    assign in_ready_o = rob_avail_q & ~flush_i & out_ready_i;

    for (genvar i = 0; i < 2; i++) begin : g_lane
        assign issue_o[i]     = in_valid_i & in_ready_o & lane_valid_i[i];
        assign spec_we_o[i]   = issue_o[i] & dst_we_i[i] & (|dst_areg_i[i]);
        assign commit_we_o[i] = retire_i[i] & ret_we_i[i] & (|ret_areg_i[i]); // r0 never committed
    end

    // lane1 only takes the next id if lane0 used the head
    assign dst_robid_o[0] = head_q;
    assign dst_robid_o[1] = issue_o[0] ? head_q + 1'b1 : head_q;

    always_comb begin
        n_issue  = '0;
        n_retire = '0;
        n_issue  = n_issue + issue_o[0] + issue_o[1];
        n_retire = n_retire + retire_i[0] + retire_i[1];
        rob_cnt_d = rob_cnt_q + n_issue - n_retire;
        head_d    = head_q + n_issue[ROB_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            rob_cnt_q   <= '0;
            head_q      <= '0;
            rob_avail_q <= 1'b1;
        end else begin
            rob_cnt_q   <= rob_cnt_d;
            head_q      <= head_d;
            rob_avail_q <= (rob_cnt_d <= ROB_HEADROOM);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/spec_rat.sv ====
`timescale 1ns/1ps
`default_nettype none

module spec_rat import rename_pkg::*; (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    flush_i,
    input  wire  [3:0][AREG_W-1:0] src_areg_i,
    input  wire  [1:0][AREG_W-1:0] dst_areg_i,
    input  wire  [1:0]             we_i,
    input  rat_entry_t [1:0]       wentry_i,
    output rat_entry_t [3:0]       rentry_o,
    output logic [3:0]             bypass_o
);

    rat_entry_t rat_q [AREG_NUM];

    // lane1 write lands last, so it wins on a shared destination
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            for (int r = 0; r < AREG_NUM; r++) begin
                rat_q[r] <= '0;
            end
        end else begin
            if (we_i[0]) begin
                rat_q[dst_areg_i[0]] <= wentry_i[0];
            end
            if (we_i[1]) begin
                rat_q[dst_areg_i[1]] <= wentry_i[1];
            end
        end
    end

    always_comb begin
        for (int s = 0; s < 4; s++) begin
            rentry_o[s] = rat_q[src_areg_i[s]];
            bypass_o[s] = 1'b0;
        end
        // lane1 sources see lane0's new mapping
        for (int s = 2; s < 4; s++) begin
            if (we_i[0] && (src_areg_i[s] == dst_areg_i[0])) begin
                rentry_o[s] = wentry_i[0];
                bypass_o[s] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/commit_rat.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_rat import rename_pkg::*; (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    flush_i,
    input  wire  [5:0][AREG_W-1:0] raddr_i,  // 0..3 sources, 4..5 destinations
    input  wire  [1:0][AREG_W-1:0] waddr_i,
    input  wire  [1:0]             we_i,
    input  rat_entry_t [1:0]       wentry_i,
    output rat_entry_t [5:0]       rentry_o
);

    rat_entry_t crat_q [AREG_NUM];

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            for (int r = 0; r < AREG_NUM; r++) begin
                crat_q[r] <= '0;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (we_i[k]) begin
                    crat_q[waddr_i[k]] <= wentry_i[k];
                end
            end
        end
    end

    // retire in this cycle is visible right away, port 1 last
    always_comb begin
        for (int p = 0; p < 6; p++) begin
            rentry_o[p] = crat_q[raddr_i[p]];
            for (int k = 0; k < 2; k++) begin
                if (we_i[k] && (waddr_i[k] == raddr_i[p])) begin
                    rentry_o[p] = wentry_i[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/arch_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module arch_regfile import rename_pkg::*; (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire  [3:0][AREG_W-1:0] raddr_i,
    input  wire  [1:0][AREG_W-1:0] waddr_i,
    input  wire  [1:0]             we_i,
    input  wire  [1:0][XLEN-1:0]   wdata_i,
    output logic [3:0][XLEN-1:0]   rdata_o
);

    logic [XLEN-1:0] regs_q [AREG_NUM];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < AREG_NUM; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (we_i[k]) begin
                    regs_q[waddr_i[k]] <= wdata_i[k];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata_o[p] = regs_q[raddr_i[p]];
            for (int k = 0; k < 2; k++) begin
                if (we_i[k] && (waddr_i[k] == raddr_i[p])) begin
                    rdata_o[p] = wdata_i[k]; // bypass retire data
                end
            end
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rename_out_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_out_reg import rename_pkg::*; (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    flush_i,
    input  wire                    accept_i,
    input  wire  [1:0]             lane_valid_i,
    input  wire  [3:0]             src_need_i,
    input  wire  [3:0][AREG_W-1:0] src_areg_i,
    input  rat_entry_t [3:0]       spec_entry_i,
    input  rat_entry_t [3:0]       commit_entry_i,
    input  wire  [3:0]             bypass_i,
    input  wire  [3:0][XLEN-1:0]   arf_data_i,
    input  wire  [1:0][ROB_W-1:0]  dst_robid_i,
    input  wire  [1:0]             dst_check_i,
    input  wire                    out_ready_i,
    output logic                   out_valid_o,
    output logic [1:0]             out_lane_valid_o,
    output logic [3:0][ROB_W-1:0]  out_src_robid_o,
    output logic [3:0]             out_src_ready_o,
    output logic [3:0][XLEN-1:0]   out_src_data_o,
    output logic [1:0][ROB_W-1:0]  out_dst_robid_o,
    output logic [1:0]             out_dst_check_o
);

    logic [3:0] src_ready;

    // mapping agrees with committed state -> arf value is current
    for (genvar s = 0; s < 4; s++) begin : g_rdy
        assign src_ready[s] = ~src_need_i[s]
                            | (src_areg_i[s] == '0)
                            | ((spec_entry_i[s] == commit_entry_i[s]) & ~bypass_i[s]);
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            out_valid_o      <= 1'b0;
            out_lane_valid_o <= '0;
        end else if (out_ready_i) begin
            out_valid_o      <= accept_i;
            out_lane_valid_o <= lane_valid_i & {2{accept_i}};
        end
    end

    // payload only moves with an accepted bundle
    always_ff @(posedge clk) begin
        if (out_ready_i && accept_i) begin
            for (int s = 0; s < 4; s++) begin
                out_src_robid_o[s] <= spec_entry_i[s].robid;
            end
            out_src_ready_o <= src_ready;
            out_src_data_o  <= arf_data_i;
            out_dst_robid_o <= dst_robid_i;
            out_dst_check_o <= dst_check_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rename_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_stage import rename_pkg::*; (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    flush_i,
    // decode side
    input  wire                    in_valid_i,
    output logic                   in_ready_o,
    input  wire  [1:0]             lane_valid_i,
    input  wire  [3:0][AREG_W-1:0] src_areg_i,
    input  wire  [3:0]             src_need_i,
    input  wire  [1:0][AREG_W-1:0] dst_areg_i,
    input  wire  [1:0]             dst_we_i,
    // next stage
    output logic                   out_valid_o,
    input  wire                    out_ready_i,
    output logic [1:0]             out_lane_valid_o,
    output logic [3:0][ROB_W-1:0]  out_src_robid_o,
    output logic [3:0]             out_src_ready_o,
    output logic [3:0][XLEN-1:0]   out_src_data_o,
    output logic [1:0][ROB_W-1:0]  out_dst_robid_o,
    output logic [1:0]             out_dst_check_o,
    // retire ports
    input  wire  [1:0]             retire_i,
    input  wire  [1:0]             ret_we_i,
    input  wire  [1:0][AREG_W-1:0] ret_areg_i,
    input  wire  [1:0][ROB_W-1:0]  ret_robid_i,
    input  wire  [1:0]             ret_check_i,
    input  wire  [1:0][XLEN-1:0]   ret_data_i
);

    logic [1:0]            issue, spec_we, commit_we, dst_check;
    logic [1:0][ROB_W-1:0] dst_robid;
    logic [3:0]            bypass;
    rat_entry_t [3:0]      spec_entry;
    rat_entry_t [5:0]      commit_entry;
    rat_entry_t [1:0]      new_entry, ret_entry;
    logic [3:0][XLEN-1:0]  arf_data;

    for (genvar i = 0; i < 2; i++) begin : g_entry
        assign dst_check[i]       = ~commit_entry[4+i].check; // flip vs committed
        assign new_entry[i].check = dst_check[i];
        assign new_entry[i].robid = dst_robid[i];
        assign ret_entry[i].check = ret_check_i[i];
        assign ret_entry[i].robid = ret_robid_i[i];
    end

    rename_ctrl u_ctrl (
        .clk(clk), .reset_i(reset_i), .flush_i(flush_i),
        .in_valid_i(in_valid_i), .lane_valid_i(lane_valid_i),
        .dst_areg_i(dst_areg_i), .dst_we_i(dst_we_i), .out_ready_i(out_ready_i),
        .retire_i(retire_i), .ret_we_i(ret_we_i), .ret_areg_i(ret_areg_i),
        .in_ready_o(in_ready_o), .issue_o(issue), .spec_we_o(spec_we),
        .commit_we_o(commit_we), .dst_robid_o(dst_robid)
    );

    spec_rat u_spec_rat (
        .clk(clk), .reset_i(reset_i), .flush_i(flush_i),
        .src_areg_i(src_areg_i), .dst_areg_i(dst_areg_i),
        .we_i(spec_we), .wentry_i(new_entry),
        .rentry_o(spec_entry), .bypass_o(bypass)
    );

    commit_rat u_commit_rat (
        .clk(clk), .reset_i(reset_i), .flush_i(flush_i),
        .raddr_i({dst_areg_i, src_areg_i}),
        .waddr_i(ret_areg_i), .we_i(commit_we), .wentry_i(ret_entry),
        .rentry_o(commit_entry)
    );

    arch_regfile u_arf (
        .clk(clk), .reset_i(reset_i),
        .raddr_i(src_areg_i), .waddr_i(ret_areg_i),
        .we_i(commit_we), .wdata_i(ret_data_i), .rdata_o(arf_data)
    );

    rename_out_reg u_out_reg (
        .clk(clk), .reset_i(reset_i), .flush_i(flush_i),
        .accept_i(|issue), .lane_valid_i(issue),
        .src_need_i(src_need_i), .src_areg_i(src_areg_i),
        .spec_entry_i(spec_entry), .commit_entry_i(commit_entry[3:0]),
        .bypass_i(bypass), .arf_data_i(arf_data),
        .dst_robid_i(dst_robid), .dst_check_i(dst_check), .out_ready_i(out_ready_i),
        .out_valid_o(out_valid_o), .out_lane_valid_o(out_lane_valid_o),
        .out_src_robid_o(out_src_robid_o), .out_src_ready_o(out_src_ready_o),
        .out_src_data_o(out_src_data_o), .out_dst_robid_o(out_dst_robid_o),
        .out_dst_check_o(out_dst_check_o)
    );

endmodule

`default_nettype wire

// ==== test/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen import rename_pkg::*; (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #5 clk_o = ~clk_o; // 10 ns period

endmodule

`default_nettype wire

// ==== test/rename_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_sva import rename_pkg::*; (
    input wire                  clk,
    input wire                  reset_i,
    input wire                  flush_i,
    input wire                  in_ready_o,
    input wire                  out_valid_o,
    input wire                  out_ready_i,
    input wire [1:0]            out_lane_valid_o,
    input wire [3:0][ROB_W-1:0] out_src_robid_o,
    input wire [3:0]            out_src_ready_o,
    input wire [3:0][XLEN-1:0]  out_src_data_o,
    input wire [1:0][ROB_W-1:0] out_dst_robid_o,
    input wire [1:0]            out_dst_check_o
);

    logic [172:0] out_bundle;

    assign out_bundle = {out_valid_o, out_lane_valid_o, out_src_robid_o, out_src_ready_o,
                         out_src_data_o, out_dst_robid_o, out_dst_check_o};

    no_accept_in_flush: assert property (@(posedge clk) flush_i |-> !in_ready_o)
        else $error("in_ready_o high while flush_i is set");

    // stalled output keeps its bundle
    hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
        (out_valid_o && !out_ready_i && !flush_i) |=> $stable(out_bundle))
        else $error("output bundle changed while out_ready_i was low");

    valid_low_after_reset: assert property (@(posedge clk) reset_i |=> !out_valid_o)
        else $error("out_valid_o set in the cycle after reset");

endmodule

`default_nettype wire

// ==== test/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

    localparam int RAND_STEPS  = 250;
    localparam int FILL_MAX    = 80;
    localparam int TAIL_STEPS  = 100;
    // fixed steps around the loops add up to 20
    localparam int NUM_BUNDLES = RAND_STEPS + 2 * FILL_MAX + TAIL_STEPS + 20;

    typedef struct packed {
        logic [1:0]            lane_valid;
        logic [3:0][ROB_W-1:0] src_robid;
        logic [3:0]            src_ready;
        logic [3:0][XLEN-1:0]  src_data;
        logic [1:0][ROB_W-1:0] dst_robid;
        logic [1:0]            dst_check;
    } bundle_t;

    typedef struct packed {
        logic [AREG_W-1:0] areg;
        logic              we;
        logic [ROB_W-1:0]  robid;
        logic              check;
    } rob_rec_t;

    logic                   clk;
    logic                   reset_i;
    logic                   flush_i;
    logic                   in_valid_i;
    logic                   in_ready_o;
    logic [1:0]             lane_valid_i;
    logic [3:0][AREG_W-1:0] src_areg_i;
    logic [3:0]             src_need_i;
    logic [1:0][AREG_W-1:0] dst_areg_i;
    logic [1:0]             dst_we_i;
    logic                   out_valid_o;
    logic                   out_ready_i;
    logic [1:0]             out_lane_valid_o;
    logic [3:0][ROB_W-1:0]  out_src_robid_o;
    logic [3:0]             out_src_ready_o;
    logic [3:0][XLEN-1:0]   out_src_data_o;
    logic [1:0][ROB_W-1:0]  out_dst_robid_o;
    logic [1:0]             out_dst_check_o;
    logic [1:0]             retire_i;
    logic [1:0]             ret_we_i;
    logic [1:0][AREG_W-1:0] ret_areg_i;
    logic [1:0][ROB_W-1:0]  ret_robid_i;
    logic [1:0]             ret_check_i;
    logic [1:0][XLEN-1:0]   ret_data_i;

    // model state as it will be after the coming edge
    rat_entry_t       srat_m [AREG_NUM];
    rat_entry_t       crat_m [AREG_NUM];
    logic [XLEN-1:0]  rf_m [AREG_NUM];
    logic [ROB_W-1:0] head_m;
    logic             avail_m;
    rob_rec_t         rob_q [$];   // issued, not yet retired
    bundle_t          exp_q [$];
    logic             accept_now;
    logic [255:0]     held;
    integer           seed = 32'hd967_f912;

    clk_gen u_clk (.clk_o(clk));

    rename_stage uut (.*);

    bind rename_stage rename_sva u_sva (
        .clk(clk), .reset_i(reset_i), .flush_i(flush_i), .in_ready_o(in_ready_o),
        .out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
        .out_lane_valid_o(out_lane_valid_o), .out_src_robid_o(out_src_robid_o),
        .out_src_ready_o(out_src_ready_o), .out_src_data_o(out_src_data_o),
        .out_dst_robid_o(out_dst_robid_o), .out_dst_check_o(out_dst_check_o)
    );

    task automatic check_eq(input logic [255:0] got, input logic [255:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    function automatic logic [255:0] out_snapshot();
        return {out_valid_o, out_lane_valid_o, out_src_robid_o, out_src_ready_o,
                out_src_data_o, out_dst_robid_o, out_dst_check_o};
    endfunction

    // expected bundle for the inputs now on the bus
    function automatic bundle_t predict_bundle();
        bundle_t         b;
        rat_entry_t      ce [AREG_NUM];
        logic [XLEN-1:0] rf [AREG_NUM];
        rat_entry_t      new_e0;
        rat_entry_t      e;
        logic            byp;
        logic            lane0_we;
        ce = crat_m;
        rf = rf_m;
        for (int k = 0; k < 2; k++) begin
            if (retire_i[k] && ret_we_i[k] && ret_areg_i[k] != '0) begin
                ce[ret_areg_i[k]] = {ret_check_i[k], ret_robid_i[k]};
                rf[ret_areg_i[k]] = ret_data_i[k];
            end
        end
        b.lane_valid   = lane_valid_i;
        b.dst_robid[0] = head_m;
        b.dst_robid[1] = lane_valid_i[0] ? head_m + 1'b1 : head_m;
        for (int i = 0; i < 2; i++) begin
            b.dst_check[i] = ~ce[dst_areg_i[i]].check; // new id flips the committed check
        end
        new_e0   = {b.dst_check[0], b.dst_robid[0]};
        lane0_we = lane_valid_i[0] && dst_we_i[0] && dst_areg_i[0] != '0;
        for (int s = 0; s < 4; s++) begin
            e   = srat_m[src_areg_i[s]];
            byp = 1'b0;
            if (s >= 2 && lane0_we && src_areg_i[s] == dst_areg_i[0]) begin
                e   = new_e0;
                byp = 1'b1;
            end
            b.src_robid[s] = e.robid;
            b.src_ready[s] = !src_need_i[s] || src_areg_i[s] == '0
                             || (e == ce[src_areg_i[s]] && !byp);
            b.src_data[s]  = (src_areg_i[s] == '0) ? '0 : rf[src_areg_i[s]];
        end
        return b;
    endfunction

    // one cycle of stimulus, ret_mode 0 none, 1 random, 2 as many as possible
    task automatic step(input logic rst, input logic fl, input logic in_v,
                        input logic out_rdy, input int ret_mode);
        logic [31:0] rnd;
        int          n_ret;
        logic        exp_ready;
        bundle_t     b;
        rob_rec_t    rec;
        @(negedge clk);
        rnd          = $random(seed);
        reset_i      = rst;
        flush_i      = fl;
        in_valid_i   = in_v;
        out_ready_i  = out_rdy;
        lane_valid_i = (rnd[25:24] == 2'b00) ? 2'b11 : rnd[25:24];
        for (int s = 0; s < 4; s++) begin
            src_areg_i[s] = {2'b00, rnd[3*s +: 3]}; // few registers, many dependencies
        end
        dst_areg_i[0] = {2'b00, rnd[14:12]};
        dst_areg_i[1] = {2'b00, rnd[17:15]};
        src_need_i    = rnd[21:18];
        dst_we_i      = rnd[23:22] | rnd[29:28];
        retire_i      = '0;
        ret_we_i      = '0;
        ret_areg_i    = '0;
        ret_robid_i   = '0;
        ret_check_i   = '0;
        ret_data_i    = '0;
        n_ret = (ret_mode == 2) ? 2 : (ret_mode == 1) ? int'(rnd[26]) + int'(rnd[27]) : 0;
        if (n_ret > rob_q.size()) begin
            n_ret = rob_q.size();
        end
        for (int k = 0; k < n_ret; k++) begin
            retire_i[k]    = 1'b1;
            ret_we_i[k]    = rob_q[k].we;
            ret_areg_i[k]  = rob_q[k].areg;
            ret_robid_i[k] = rob_q[k].robid;
            ret_check_i[k] = rob_q[k].check;
            ret_data_i[k]  = $random(seed);
        end
        #1;
        exp_ready = !rst && avail_m && !fl && out_rdy;
        if (!rst) begin
            check_eq(in_ready_o, exp_ready, "in_ready_o");
        end
        accept_now = !rst && in_v && exp_ready;
        if (accept_now) begin
            b = predict_bundle();
            exp_q.push_back(b);
        end
        if (rst || fl) begin
            for (int r = 0; r < AREG_NUM; r++) begin
                srat_m[r] = '0;
                crat_m[r] = '0;
                if (rst) begin
                    rf_m[r] = '0;
                end
            end
            rob_q.delete();
            head_m  = '0;
            avail_m = 1'b1;
        end else begin
            for (int k = 0; k < n_ret; k++) begin
                rec = rob_q.pop_front();
                if (rec.we && rec.areg != '0) begin
                    crat_m[rec.areg] = {rec.check, rec.robid};
                    rf_m[rec.areg]   = ret_data_i[k];
                end
            end
            for (int i = 0; i < 2; i++) begin
                if (accept_now && lane_valid_i[i]) begin
                    rec.areg  = dst_areg_i[i];
                    rec.we    = dst_we_i[i];
                    rec.robid = b.dst_robid[i];
                    rec.check = b.dst_check[i];
                    rob_q.push_back(rec);
                    if (rec.we && rec.areg != '0) begin
                        srat_m[rec.areg] = {rec.check, rec.robid};
                    end
                    head_m = head_m + 1'b1;
                end
            end
            avail_m = (rob_q.size() <= ROB_HEADROOM);
        end
    endtask

    // outputs settle shortly after the edge
    always @(posedge clk) begin
        bundle_t exp_b;
        #2;
        if (reset_i || flush_i) begin
            check_eq(out_valid_o, 1'b0, "out_valid_o after reset or flush");
        end else if (accept_now) begin
            exp_b = exp_q.pop_front();
            check_eq(out_valid_o, 1'b1, "out_valid_o");
            check_eq(out_lane_valid_o, exp_b.lane_valid, "out_lane_valid_o");
            for (int i = 0; i < 2; i++) begin
                if (exp_b.lane_valid[i]) begin
                    check_eq(out_dst_robid_o[i], exp_b.dst_robid[i],
                             $sformatf("out_dst_robid_o[%0d]", i));
                    check_eq(out_dst_check_o[i], exp_b.dst_check[i],
                             $sformatf("out_dst_check_o[%0d]", i));
                    for (int s = 2 * i; s < 2 * i + 2; s++) begin
                        check_eq(out_src_robid_o[s], exp_b.src_robid[s],
                                 $sformatf("out_src_robid_o[%0d]", s));
                        check_eq(out_src_ready_o[s], exp_b.src_ready[s],
                                 $sformatf("out_src_ready_o[%0d]", s));
                        check_eq(out_src_data_o[s], exp_b.src_data[s],
                                 $sformatf("out_src_data_o[%0d]", s));
                    end
                end
            end
        end else if (out_ready_i) begin
            check_eq(out_valid_o, 1'b0, "out_valid_o without an accepted bundle");
        end else begin
            check_eq(out_snapshot(), held, "outputs under back-pressure");
        end
        held = out_snapshot();
    end

    initial begin
        #(NUM_BUNDLES * 20 * 10);
        $display("Watchdog timeout: the run did not end within %0d cycles", NUM_BUNDLES * 20);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        int guard;
        reset_i      = 1'b1;
        flush_i      = 1'b0;
        in_valid_i   = 1'b0;
        lane_valid_i = '0;
        src_areg_i   = '0;
        src_need_i   = '0;
        dst_areg_i   = '0;
        dst_we_i     = '0;
        out_ready_i  = 1'b1;
        retire_i     = '0;
        ret_we_i     = '0;
        ret_areg_i   = '0;
        ret_robid_i  = '0;
        ret_check_i  = '0;
        ret_data_i   = '0;
        accept_now   = 1'b0;
        head_m       = '0;
        avail_m      = 1'b1;
        // the first edge already sees reset from time 0
        repeat (4) step(1'b1, 1'b0, 1'b0, 1'b1, 0);
        repeat (RAND_STEPS) step(1'b0, 1'b0, chance(85), chance(80), 1);
        // fill the ROB with nothing retiring
        guard = 0;
        while (avail_m && guard < FILL_MAX) begin
            step(1'b0, 1'b0, 1'b1, 1'b1, 0);
            guard++;
        end
        check_eq(avail_m, 1'b0, "reorder buffer never reached its limit");
        repeat (4) step(1'b0, 1'b0, 1'b1, 1'b1, 0);
        guard = 0;
        while (!avail_m && guard < FILL_MAX) begin
            step(1'b0, 1'b0, 1'b0, 1'b1, 2);
            guard++;
        end
        check_eq(avail_m, 1'b1, "reorder buffer did not drain after retires");
        repeat (2) step(1'b0, 1'b0, 1'b1, 1'b1, 1);
        repeat (6) step(1'b0, 1'b0, 1'b1, 1'b0, 1); // stalled next stage
        step(1'b0, 1'b1, 1'b1, 1'b1, 0);
        repeat (TAIL_STEPS) step(1'b0, 1'b0, chance(85), chance(90), 1);
        repeat (3) step(1'b0, 1'b0, 1'b0, 1'b1, 0);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/rename_pkg.sv
rtl/rename_ctrl.sv
rtl/spec_rat.sv
rtl/commit_rat.sv
rtl/arch_regfile.sv
rtl/rename_out_reg.sv
rtl/rename_stage.sv
test/clk_gen.sv
test/rename_sva.sv
test/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  - rtl/rename_pkg.sv
  - rtl/rename_ctrl.sv
  - rtl/spec_rat.sv
  - rtl/commit_rat.sv
  - rtl/arch_regfile.sv
  - rtl/rename_out_reg.sv
  - rtl/rename_stage.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/rename_sva.sv
      - test/rename_tb.sv
